// ==== compile.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_monitor.sv
tests/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
SRCS      := $(shell grep -v '^+' $(FILELIST)) include/dcache_consts.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall -Iinclude verilog/*.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/dcache_tb.sv ====
// Testbench for the data cache: drives CPU requests, models the memory slave
// with random delays, and keeps a shadow memory for the expected results.
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

  localparam int N_RAND  = 200;
  localparam int N_REQ   = 62 + N_RAND;      // requests over all tests
  localparam int LIMIT   = N_REQ * 400 + 16 + 64;
  localparam int SEED    = 32'h8874_ab05;

  logic  clk = 1'b0;
  logic  rst;
  logic  ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
  logic  w_valid, w_ready, b_valid, b_ready;
  addr_t ar_addr, aw_addr, mem_aw_addr, mem_ar_addr, wb_addr, rd_addr, req_line;
  word_t r_data, w_data, mem_w_data, exp_r_data, wb_exp;
  strb_t w_strb;
  logic  mem_aw_valid, mem_w_valid, mem_b_ready, mem_ar_valid, mem_r_ready;
  logic  mem_aw_ready = 1'b0;
  logic  mem_w_ready  = 1'b0;
  logic  mem_ar_ready = 1'b0;
  logic  mem_b_valid  = 1'b0;
  logic  mem_r_valid  = 1'b0;
  word_t mem_r_data   = '0;
  logic  wb_known, b_pend, r_pend, test_end, done;
  int    test_num, exp_ar, aw_min, aw_max, err_count;
  int    cycles = 0;
  word_t shadow  [addr_t];
  word_t backing [addr_t];

  always #20 clk = ~clk;

  dcache_top UUT (
    .clk(clk), .rst(rst),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .mem_aw_valid_o(mem_aw_valid), .mem_aw_ready_i(mem_aw_ready), .mem_aw_addr_o(mem_aw_addr),
    .mem_w_valid_o(mem_w_valid), .mem_w_ready_i(mem_w_ready), .mem_w_data_o(mem_w_data),
    .mem_b_valid_i(mem_b_valid), .mem_b_ready_o(mem_b_ready),
    .mem_ar_valid_o(mem_ar_valid), .mem_ar_ready_i(mem_ar_ready), .mem_ar_addr_o(mem_ar_addr),
    .mem_r_valid_i(mem_r_valid), .mem_r_ready_o(mem_r_ready), .mem_r_data_i(mem_r_data)
  );

  dcache_monitor mon (
    .clk(clk), .rst(rst), .ar_ready_i(ar_ready), .aw_ready_i(aw_ready),
    .r_valid_i(r_valid), .r_ready_i(r_ready), .r_data_i(r_data), .b_valid_i(b_valid),
    .exp_r_data_i(exp_r_data),
    .mem_aw_valid_i(mem_aw_valid), .mem_aw_ready_i(mem_aw_ready),
    .mem_w_valid_i(mem_w_valid), .mem_w_ready_i(mem_w_ready), .mem_w_data_i(mem_w_data),
    .wb_exp_i(wb_exp), .wb_known_i(wb_known),
    .mem_ar_valid_i(mem_ar_valid), .mem_ar_ready_i(mem_ar_ready),
    .mem_ar_addr_i(mem_ar_addr), .req_line_i(req_line),
    .test_num_i(test_num), .test_end_i(test_end), .exp_ar_i(exp_ar),
    .aw_min_i(aw_min), .aw_max_i(aw_max), .done_i(done), .error_count_o(err_count)
  );

  function automatic addr_t line_of(input addr_t a);
    return {a[31:3], 3'b000};
  endfunction

  // backing memory contents before any writeback
  function automatic word_t init_word(input addr_t a);
    return {a ^ 32'hc3a5_1e0f, ~a + 32'h0000_0101};
  endfunction

  function automatic word_t merge_strobes(input word_t old, input word_t d, input strb_t s);
    word_t res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (s[b])
        res[8*b +: 8] = d[8*b +: 8];
    end
    return res;
  endfunction

  function automatic word_t expected_read(input addr_t a);
    addr_t l;
    l = line_of(a);
    return shadow.exists(l) ? shadow[l] : init_word(l);
  endfunction

  function automatic word_t backing_read(input addr_t a);
    return backing.exists(a) ? backing[a] : init_word(a);
  endfunction

  // sets 0..7 for mixed traffic, set 8 for the eviction test
  function automatic addr_t pool_addr(input int s, input int t);
    index_t idx;
    tag_t   tg;
    idx = index_t'(s * 7 + 3);
    tg  = tag_t'(32'h1_2000 + t * 32'h3_5a1 + s);
    return {tg, idx, 3'b000};
  endfunction

  // memory slave with random ready and response delays
  always @(posedge clk) begin
    if (rst) begin
      mem_aw_ready <= 1'b0;
      mem_w_ready  <= 1'b0;
      mem_ar_ready <= 1'b0;
      mem_b_valid  <= 1'b0;
      mem_r_valid  <= 1'b0;
      b_pend       <= 1'b0;
      r_pend       <= 1'b0;
    end else begin
      mem_aw_ready <= ($urandom_range(0, 2) == 0);
      mem_w_ready  <= ($urandom_range(0, 2) == 0);
      mem_ar_ready <= ($urandom_range(0, 2) == 0);
      if (mem_aw_valid && mem_aw_ready) begin
        wb_addr  <= mem_aw_addr;
        wb_exp   <= expected_read(mem_aw_addr);
        wb_known <= shadow.exists(mem_aw_addr);
      end
      if (mem_w_valid && mem_w_ready) begin
        backing[wb_addr] = mem_w_data;
        b_pend <= 1'b1;
      end
      if (mem_b_valid && mem_b_ready)
        mem_b_valid <= 1'b0;
      else if (b_pend && $urandom_range(0, 1) == 0) begin
        mem_b_valid <= 1'b1;
        b_pend      <= 1'b0;
      end
      if (mem_ar_valid && mem_ar_ready) begin
        rd_addr <= mem_ar_addr;
        r_pend  <= 1'b1;
      end
      if (mem_r_valid && mem_r_ready)
        mem_r_valid <= 1'b0;
      else if (r_pend && $urandom_range(0, 3) == 0) begin
        mem_r_valid <= 1'b1;
        mem_r_data  <= backing_read(rd_addr);
        r_pend      <= 1'b0;
      end
    end
  end

  task automatic cpu_read(input addr_t a);
    @(posedge clk);
    ar_valid   <= 1'b1;
    ar_addr    <= a;
    r_ready    <= 1'b1;
    exp_r_data <= expected_read(a);
    req_line   <= line_of(a);
    do @(posedge clk); while (!ar_ready);
    ar_valid <= 1'b0;
    forever begin
      @(posedge clk);
      if (r_valid && r_ready)
        break;
      r_ready <= ($urandom_range(0, 3) != 0);  // some back-pressure
    end
    r_ready <= 1'b0;
  endtask

  task automatic cpu_write(input addr_t a, input word_t d, input strb_t s);
    @(posedge clk);
    aw_valid <= 1'b1;
    aw_addr  <= a;
    req_line <= line_of(a);
    shadow[line_of(a)] = merge_strobes(expected_read(a), d, s);
    do @(posedge clk); while (!aw_ready);
    aw_valid <= 1'b0;
    w_valid  <= 1'b1;
    w_data   <= d;
    w_strb   <= s;
    do @(posedge clk); while (!w_ready);
    w_valid <= 1'b0;
    b_ready <= 1'b1;
    do @(posedge clk); while (!b_valid);
    b_ready <= 1'b0;
  endtask

  task automatic end_test(input int ar, input int aw_lo, input int aw_hi);
    @(posedge clk);
    exp_ar   <= ar;
    aw_min   <= aw_lo;
    aw_max   <= aw_hi;
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_num <= test_num + 1;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    {ar_valid, r_ready, aw_valid, w_valid, b_ready, test_end, done} = '0;
    {ar_addr, aw_addr, w_data, w_strb} = '0;
    {test_num, exp_ar, aw_min, aw_max} = {32'd1, 32'd0, 32'd0, 32'd0};
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    end_test(0, 0, 0);  // reset state, checked on release
    for (int s = 0; s < 8; s++)
      cpu_read(pool_addr(s, 0));
    end_test(8, 0, 0);
    for (int s = 0; s < 8; s++)
      cpu_read(pool_addr(s, 0));
    end_test(0, 0, 0);
    for (int s = 0; s < 8; s++) begin
      cpu_write(pool_addr(s, 0), {$urandom, $urandom}, strb_t'($urandom));
      cpu_read(pool_addr(s, 0));
    end
    end_test(0, 0, 0);
    for (int t = 0; t < 3; t++)
      cpu_write(pool_addr(8, t), {$urandom, $urandom}, 8'hff);
    for (int t = 0; t < 3; t++)
      cpu_read(pool_addr(8, t));
    end_test(-1, 1, 6);
    for (int i = 0; i < N_RAND; i++) begin
      if ($urandom_range(0, 1) == 0)
        cpu_read(pool_addr($urandom_range(0, 7), $urandom_range(0, 2)));
      else
        cpu_write(pool_addr($urandom_range(0, 7), $urandom_range(0, 2)),
                  {$urandom, $urandom}, strb_t'($urandom));
    end
    for (int s = 0; s < 8; s++) begin
      for (int t = 0; t < 3; t++)
        cpu_read(pool_addr(s, t));
    end
    end_test(-1, 0, N_REQ);
    @(posedge clk);
    done <= 1'b1;
    @(posedge clk);
    done <= 1'b0;
    @(posedge clk);
    if (err_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/dcache_monitor.sv ====
// Watches the cache ports, compares read data, fill addresses and writeback data
// with the expected values from the testbench, and counts memory transactions per test.
`timescale 1ns/1ps
`default_nettype none

module dcache_monitor import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  ar_ready_i,
  input  logic  aw_ready_i,
  input  logic  r_valid_i,
  input  logic  r_ready_i,
  input  word_t r_data_i,
  input  logic  b_valid_i,
  input  word_t exp_r_data_i,
  input  logic  mem_aw_valid_i,
  input  logic  mem_aw_ready_i,
  input  logic  mem_w_valid_i,
  input  logic  mem_w_ready_i,
  input  word_t mem_w_data_i,
  input  word_t wb_exp_i,
  input  logic  wb_known_i,
  input  logic  mem_ar_valid_i,
  input  logic  mem_ar_ready_i,
  input  addr_t mem_ar_addr_i,
  input  addr_t req_line_i,
  input  int    test_num_i,
  input  logic  test_end_i,
  input  int    exp_ar_i,
  input  int    aw_min_i,
  input  int    aw_max_i,
  input  logic  done_i,
  output int    error_count_o
);

  int   err_cnt = 0;
  int   chk_cnt = 0;
  int   test_cnt = 0;
  int   err_base = 0;
  int   ar_cnt = 0;
  int   aw_cnt = 0;
  logic rst_q = 1'b1;

  assign error_count_o = err_cnt;

  task automatic compare_word(input string name, input word_t exp, input word_t got);
    chk_cnt++;
    if (exp !== got) begin
      err_cnt++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  always @(posedge clk) begin
    rst_q <= rst;
    if (!rst && rst_q) begin  // first cycle out of reset
      compare_word("ar_ready_o", 64'(1), 64'(ar_ready_i));
      compare_word("aw_ready_o", 64'(1), 64'(aw_ready_i));
      compare_word("r_valid_o", 64'(0), 64'(r_valid_i));
      compare_word("b_valid_o", 64'(0), 64'(b_valid_i));
      compare_word("mem_aw_valid_o", 64'(0), 64'(mem_aw_valid_i));
      compare_word("mem_w_valid_o", 64'(0), 64'(mem_w_valid_i));
      compare_word("mem_ar_valid_o", 64'(0), 64'(mem_ar_valid_i));
    end
    if (!rst) begin
      if (mem_ar_valid_i && mem_ar_ready_i) begin
        ar_cnt++;
        compare_word("mem_ar_addr_o", 64'(req_line_i), 64'(mem_ar_addr_i));  // refill line
      end
      if (mem_aw_valid_i && mem_aw_ready_i)
        aw_cnt++;
      if (r_valid_i && r_ready_i)
        compare_word("r_data_o", exp_r_data_i, r_data_i);
      if (mem_w_valid_i && mem_w_ready_i) begin
        if (!wb_known_i) begin
          err_cnt++;
          $display("writeback of a line that was never written");
        end
        compare_word("mem_w_data_o", wb_exp_i, mem_w_data_i);
      end
      if (test_end_i) begin
        test_cnt++;
        if (exp_ar_i >= 0 && ar_cnt != exp_ar_i) begin
          err_cnt++;
          $display("test %0d expected %0d memory reads, saw %0d", test_num_i, exp_ar_i, ar_cnt);
        end
        if (aw_cnt < aw_min_i || aw_cnt > aw_max_i) begin
          err_cnt++;
          $display("test %0d expected %0d to %0d writebacks, saw %0d",
                   test_num_i, aw_min_i, aw_max_i, aw_cnt);
        end
        $display("test %0d: %s (reads %0d, writebacks %0d)", test_num_i,
                 (err_cnt == err_base) ? "ok" : "FAILED", ar_cnt, aw_cnt);
        err_base = err_cnt;
        ar_cnt   = 0;
        aw_cnt   = 0;
      end
      if (done_i)
        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    end
  end

endmodule

`default_nettype wire

// ==== tests/dcache_checker.sv ====
// Handshake and state assertions for the cache controller.
// Bound into dcache_ctrl below; reports through failing assertions only.
`timescale 1ns/1ps
`default_nettype none

module dcache_checker import dcache_pkg::*; (
  input logic      clk,
  input logic      rst,
  input dc_state_e state_i,
  input logic      ar_valid_i,
  input logic      ar_ready_i,
  input logic      aw_valid_i,
  input logic      aw_ready_i,
  input logic      r_valid_i,
  input logic      r_ready_i,
  input word_t     r_data_i,
  input logic      b_valid_i,
  input logic      b_ready_i,
  input logic      mem_aw_valid_i,
  input logic      mem_aw_ready_i,
  input logic      mem_w_valid_i,
  input logic      mem_w_ready_i,
  input logic      mem_ar_valid_i,
  input logic      mem_ar_ready_i
);

  // a taken request leaves idle and closes both address channels
  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    ((ar_valid_i && ar_ready_i) || (aw_valid_i && aw_ready_i)) |=>
      ((state_i != ST_IDLE) && !ar_ready_i && !aw_ready_i))
    else $error("address ready high outside idle");

  a_ready_busy: assert property (@(posedge clk) disable iff (rst)
    (r_valid_i || b_valid_i || mem_aw_valid_i || mem_w_valid_i || mem_ar_valid_i)
      |-> !(ar_ready_i || aw_ready_i))
    else $error("address ready high while a request is in flight");

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_data_i)))
    else $error("read data dropped before handshake");

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    (b_valid_i && !b_ready_i) |=> b_valid_i)
    else $error("write response dropped before handshake");

  // memory side valids wait for ready
  a_mem_aw_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_aw_valid_i && !mem_aw_ready_i) |=> mem_aw_valid_i)
    else $error("mem_aw_valid dropped before handshake");

  a_mem_w_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_w_valid_i && !mem_w_ready_i) |=> mem_w_valid_i)
    else $error("mem_w_valid dropped before handshake");

  a_mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_ar_valid_i && !mem_ar_ready_i) |=> mem_ar_valid_i)
    else $error("mem_ar_valid dropped before handshake");

endmodule

bind dcache_ctrl dcache_checker u_checker (
  .clk            (clk),
  .rst            (rst),
  .state_i        (state_q),
  .ar_valid_i     (ar_valid_i),
  .ar_ready_i     (ar_ready_o),
  .aw_valid_i     (aw_valid_i),
  .aw_ready_i     (aw_ready_o),
  .r_valid_i      (r_valid_o),
  .r_ready_i      (r_ready_i),
  .r_data_i       (r_data_o),
  .b_valid_i      (b_valid_o),
  .b_ready_i      (b_ready_i),
  .mem_aw_valid_i (mem_aw_valid_o),
  .mem_aw_ready_i (mem_aw_ready_i),
  .mem_w_valid_i  (mem_w_valid_o),
  .mem_w_ready_i  (mem_w_ready_i),
  .mem_ar_valid_i (mem_ar_valid_o),
  .mem_ar_ready_i (mem_ar_ready_i)
);

`default_nettype wire

// ==== verilog/dcache_top.sv ====
// Data cache top level. Joins the controller with the tag and data stores.
// CPU side is an AXI-lite style slave, memory side an AXI-lite style master.
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output word_t r_data_o,
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  addr_t aw_addr_i,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  word_t w_data_i,
  input  strb_t w_strb_i,
  output logic  b_valid_o,
  input  logic  b_ready_i,

  output logic  mem_aw_valid_o,
  input  logic  mem_aw_ready_i,
  output addr_t mem_aw_addr_o,
  output logic  mem_w_valid_o,
  input  logic  mem_w_ready_i,
  output word_t mem_w_data_o,
  input  logic  mem_b_valid_i,
  output logic  mem_b_ready_o,
  output logic  mem_ar_valid_o,
  input  logic  mem_ar_ready_i,
  output addr_t mem_ar_addr_o,
  input  logic  mem_r_valid_i,
  output logic  mem_r_ready_o,
  input  word_t mem_r_data_i
);

  tag_lookup_if tl ();
  line_ram_if   lr ();

  dcache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .tl             (tl.ctrl),
    .lr             (lr.ctrl),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_data_o       (r_data_o),
    .aw_valid_i     (aw_valid_i),
    .aw_ready_o     (aw_ready_o),
    .aw_addr_i      (aw_addr_i),
    .w_valid_i      (w_valid_i),
    .w_ready_o      (w_ready_o),
    .w_data_i       (w_data_i),
    .w_strb_i       (w_strb_i),
    .b_valid_o      (b_valid_o),
    .b_ready_i      (b_ready_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_valid_o  (mem_w_valid_o),
    .mem_w_ready_i  (mem_w_ready_i),
    .mem_w_data_o   (mem_w_data_o),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i)
  );

  dcache_tag_store u_tags (
    .clk (clk),
    .rst (rst),
    .tl  (tl.store)
  );

  dcache_data_store u_data (
    .clk (clk),
    .lr  (lr.store)
  );

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
// Cache controller FSM. Takes one CPU request at a time, decides hit or miss,
// runs the writeback and refill on the memory port, then serves the request.
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  tag_lookup_if.ctrl tl,
  line_ram_if.ctrl   lr,

  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  input  addr_t      ar_addr_i,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  output word_t      r_data_o,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  addr_t      aw_addr_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  input  word_t      w_data_i,
  input  strb_t      w_strb_i,
  output logic       b_valid_o,
  input  logic       b_ready_i,

  output logic       mem_aw_valid_o,
  input  logic       mem_aw_ready_i,
  output addr_t      mem_aw_addr_o,
  output logic       mem_w_valid_o,
  input  logic       mem_w_ready_i,
  output word_t      mem_w_data_o,
  input  logic       mem_b_valid_i,
  output logic       mem_b_ready_o,
  output logic       mem_ar_valid_o,
  input  logic       mem_ar_ready_i,
  output addr_t      mem_ar_addr_o,
  input  logic       mem_r_valid_i,
  output logic       mem_r_ready_o,
  input  word_t      mem_r_data_i
);

  dc_state_e state_q;
  dc_state_e state_d;
  addr_t     req_addr_q;
  logic      is_write_q;
  way_t      way_q;
  addr_t     in_addr;
  logic      idle;
  logic      take_aw, take_ar, take_req;
  logic      r_hs, w_hs, b_hs;
  logic      mem_aw_hs, mem_w_hs, mem_b_hs, mem_ar_hs, mem_r_hs;
  logic      fill_we, store_we;

  assign idle       = (state_q == ST_IDLE);
  assign aw_ready_o = idle;
  assign ar_ready_o = idle && !aw_valid_i;  // write wins a tie
  assign take_aw    = aw_valid_i && aw_ready_o;
  assign take_ar    = ar_valid_i && ar_ready_o;
  assign take_req   = take_aw || take_ar;
  assign in_addr    = aw_valid_i ? aw_addr_i : ar_addr_i;

  assign r_hs      = r_valid_o && r_ready_i;
  assign w_hs      = w_valid_i && w_ready_o;
  assign b_hs      = b_valid_o && b_ready_i;
  assign mem_aw_hs = mem_aw_valid_o && mem_aw_ready_i;
  assign mem_w_hs  = mem_w_valid_o && mem_w_ready_i;
  assign mem_b_hs  = mem_b_valid_i && mem_b_ready_o;
  assign mem_ar_hs = mem_ar_valid_o && mem_ar_ready_i;
  assign mem_r_hs  = mem_r_valid_i && mem_r_ready_o;

  // lookup on the incoming address in idle, the held one afterwards
  assign tl.lookup_index = idle ? addr_index(in_addr) : addr_index(req_addr_q);
  assign tl.lookup_tag   = idle ? addr_tag(in_addr) : addr_tag(req_addr_q);
  assign tl.fill_way     = idle ? tl.victim_way : way_q;
  assign tl.alloc        = take_req && !tl.hit;
  assign tl.fill_done    = mem_r_hs;
  assign tl.mark_dirty   = store_we;
  assign tl.clean        = mem_b_hs;

  assign fill_we  = mem_r_hs;
  assign store_we = (state_q == ST_HIT) && is_write_q && w_hs;

  assign lr.ram_index = addr_index(req_addr_q);
  assign lr.ram_way   = way_q;
  assign lr.ram_we    = fill_we || store_we;
  assign lr.ram_wmask = fill_we ? '1 : w_strb_i;
  assign lr.ram_wdata = fill_we ? mem_r_data_i : w_data_i;

  assign r_data_o       = lr.ram_rdata;
  assign mem_w_data_o   = lr.ram_rdata;  // victim word, read during wb_addr
  assign mem_aw_valid_o = (state_q == ST_WB_ADDR);
  assign mem_w_valid_o  = (state_q == ST_WB_DATA);
  assign mem_b_ready_o  = (state_q == ST_WB_RESP);
  assign mem_ar_valid_o = (state_q == ST_FILL_ADDR);
  assign mem_r_ready_o  = (state_q == ST_FILL_DATA);
  assign mem_aw_addr_o  = {tl.victim_tag, addr_index(req_addr_q), `DC_OFFSET_W'(0)};
  assign mem_ar_addr_o  = {addr_tag(req_addr_q), addr_index(req_addr_q), `DC_OFFSET_W'(0)};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (take_req) begin
          if (tl.hit)
            state_d = ST_HIT;
          else if (tl.victim_dirty)
            state_d = ST_WB_ADDR;
          else
            state_d = ST_FILL_ADDR;
        end
      end
      ST_HIT:       if (r_hs || b_hs) state_d = ST_IDLE;
      ST_WB_ADDR:   if (mem_aw_hs) state_d = ST_WB_DATA;
      ST_WB_DATA:   if (mem_w_hs) state_d = ST_WB_RESP;
      ST_WB_RESP:   if (mem_b_hs) state_d = ST_FILL_ADDR;
      ST_FILL_ADDR: if (mem_ar_hs) state_d = ST_FILL_DATA;
      ST_FILL_DATA: if (mem_r_hs) state_d = ST_HIT;
      default:      state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      is_write_q <= 1'b0;
      r_valid_o  <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take_req)
        is_write_q <= take_aw;
      if ((take_aw && tl.hit) || (mem_r_hs && is_write_q))
        w_ready_o <= 1'b1;
      if (w_hs) begin
        w_ready_o <= 1'b0;
        b_valid_o <= 1'b1;
      end
      if (b_hs)
        b_valid_o <= 1'b0;
      // first hit cycle reads the RAM, data valid the cycle after
      if ((state_q == ST_HIT) && !is_write_q && !r_valid_o)
        r_valid_o <= 1'b1;
      if (r_hs)
        r_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_req) begin
      req_addr_q <= in_addr;
      way_q      <= tl.hit ? tl.hit_way : tl.victim_way;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_data_store.sv ====
// Line RAM, one word array per way.
// Registered read of the addressed way, byte-masked write; fills use a full mask.
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_store import dcache_pkg::*; (
  input  logic      clk,
  line_ram_if.store lr
);

  word_t rd_all [`DC_WAYS];
  way_t  way_q;

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    word_t mem [`DC_SETS];
    word_t rd_q;

    always_ff @(posedge clk) begin
      if (lr.ram_we && (lr.ram_way == way_t'(w))) begin
        for (int b = 0; b < `DC_DATA_W/8; b++) begin
          if (lr.ram_wmask[b])
            mem[lr.ram_index][8*b +: 8] <= lr.ram_wdata[8*b +: 8];
        end
      end
      rd_q <= mem[lr.ram_index];  // old data on a same-cycle write
    end

    assign rd_all[w] = rd_q;
  end

  always_ff @(posedge clk) begin
    way_q <= lr.ram_way;
  end

  assign lr.ram_rdata = rd_all[way_q];

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_store.sv ====
// Tag, valid and dirty arrays for both ways, with the hit compare and victim pick.
// Lookups are combinational on the interface inputs; updates land on the clock edge.
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_store import dcache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  tag_lookup_if.store tl
);

  tag_t                tags_q  [`DC_WAYS][`DC_SETS];
  logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
  logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
  logic [`DC_WAYS-1:0] hit_vec;
  way_t                hit_way;
  way_t                victim_q;
  tag_t                victim_tag_q;
  index_t              idx;

  assign idx = tl.lookup_index;

  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_vec[w] = valid_q[w][idx] && (tags_q[w][idx] == tl.lookup_tag);
      if (hit_vec[w])
        hit_way = way_t'(w);
    end
  end

  assign tl.hit          = |hit_vec;
  assign tl.hit_way      = hit_way;
  assign tl.victim_way   = victim_q;
  assign tl.victim_dirty = dirty_q[victim_q][idx];  // stays set until clean
  assign tl.victim_tag   = victim_tag_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else begin
      victim_q <= victim_q + way_t'(1);  // free-running replacement
      if (tl.alloc)
        valid_q[tl.fill_way][idx] <= 1'b0;
      if (tl.fill_done)
        valid_q[tl.fill_way][idx] <= 1'b1;
      if (tl.mark_dirty)
        dirty_q[tl.fill_way][idx] <= 1'b1;
      if (tl.clean)
        dirty_q[tl.fill_way][idx] <= 1'b0;
    end
  end

  // keep old tag for the writeback address
  always_ff @(posedge clk) begin
    if (tl.alloc) begin
      victim_tag_q             <= tags_q[tl.fill_way][idx];
      tags_q[tl.fill_way][idx] <= tl.lookup_tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_ifs.sv ====
// Internal cache interfaces between the controller and the two stores.
// tag_lookup_if carries lookups and metadata updates, line_ram_if the word RAM port.
`timescale 1ns/1ps
`default_nettype none

interface tag_lookup_if import dcache_pkg::*; ();

  index_t lookup_index;
  tag_t   lookup_tag;
  way_t   fill_way;
  logic   alloc;       // new tag in, valid cleared
  logic   fill_done;
  logic   mark_dirty;
  logic   clean;

  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  logic   victim_dirty;
  tag_t   victim_tag;  // old tag, held after alloc

  modport ctrl (
    output lookup_index, lookup_tag, fill_way, alloc, fill_done, mark_dirty, clean,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport store (
    input  lookup_index, lookup_tag, fill_way, alloc, fill_done, mark_dirty, clean,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );

endinterface

interface line_ram_if import dcache_pkg::*; ();

  index_t ram_index;
  way_t   ram_way;
  logic   ram_we;
  strb_t  ram_wmask;
  word_t  ram_wdata;
  word_t  ram_rdata;   // one cycle after index

  modport ctrl  (output ram_index, ram_way, ram_we, ram_wmask, ram_wdata, input ram_rdata);
  modport store (input ram_index, ram_way, ram_we, ram_wmask, ram_wdata, output ram_rdata);

endinterface

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
// Shared types and address helpers for the data cache.
// Import with dcache_pkg::* in any module header that needs them.
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]       addr_t;
  typedef logic [`DC_DATA_W-1:0]       word_t;  // one word is one line
  typedef logic [`DC_DATA_W/8-1:0]     strb_t;
  typedef logic [`DC_TAG_W-1:0]        tag_t;
  typedef logic [`DC_INDEX_W-1:0]      index_t;
  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HIT,
    ST_WB_ADDR,
    ST_WB_DATA,
    ST_WB_RESP,
    ST_FILL_ADDR,
    ST_FILL_DATA
  } dc_state_e;

  function automatic tag_t addr_tag(input addr_t a);
    return a[`DC_ADDR_W-1 -: `DC_TAG_W];
  endfunction

  function automatic index_t addr_index(input addr_t a);
    return a[`DC_OFFSET_W +: `DC_INDEX_W];
  endfunction

endpackage

`default_nettype wire

// ==== include/dcache_consts.svh ====
// Geometry constants for the 2-way write-back data cache.
// Include wherever widths or array depths are needed; the package holds the types.
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address split  | tag 31:9 | index 8:3 | offset 2:0 |
`define DC_ADDR_W   32
`define DC_DATA_W   64
`define DC_TAG_W    23
`define DC_INDEX_W  6
`define DC_OFFSET_W 3

// 2 ways x 64 sets x 8 bytes = 1 KiB
`define DC_WAYS     2
`define DC_SETS     64

`endif
